//--- hw/mips_pkg.sv
// shared types for the single-cycle MIPS-I subset core
// only word loads/stores, no shifts, no mult/div, no exceptions
// unknown opcodes and function codes decode as a no-operation

package mips_pkg;

    // ==================================================
    // instruction encodings
    // ==================================================

    // major opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beq   = 6'h04,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } op_e;

    // r-type function field, instruction bits 5:0
    typedef enum logic [5:0] {
        fn_jr  = 6'h08,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_slt = 6'h2a
    } funct_e;

    // ==================================================
    // internal control
    // ==================================================

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        wb_alu,
        wb_mem,
        wb_link
    } wb_sel_e;

    // decoded control for one instruction, 49 bits
    typedef struct packed {
        logic        reg_write;
        logic [4:0]  wr_addr;
        logic        alu_src;
        alu_op_e     alu_op;
        logic        mem_read;
        logic        mem_write;
        wb_sel_e     wb_sel;
        logic        branch;
        logic        jump;
        logic        jump_reg;
        // sign-extended immediate, or the 26-bit target index for j/jal
        logic [31:0] imm;
    } ctrl_t;

endpackage

//--- hw/mips_decode.sv
// purely combinational instruction decoder
// unsupported opcodes or function codes give no write and no memory access
// for j/jal the imm field carries the zero-extended 26-bit target index

`timescale 1ns/1ns

module mips_decode
    import mips_pkg::*;
(
    input  logic [31:0] ir,
    output ctrl_t       ctrl,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr
);

    op_e        opcode;
    funct_e     funct;
    logic [4:0] rd_addr;
    logic [31:0] imm_sext;

    assign opcode   = op_e'(ir[31:26]);
    assign funct    = funct_e'(ir[5:0]);
    assign rs_addr  = ir[25:21];
    assign rt_addr  = ir[20:16];
    assign rd_addr  = ir[15:11];
    assign imm_sext = {{16{ir[15]}}, ir[15:0]};

    always_comb begin
        // no-operation defaults
        ctrl           = '0;
        ctrl.alu_op    = alu_add;
        ctrl.wb_sel    = wb_alu;
        ctrl.imm       = imm_sext;

        case (opcode)
            op_rtype: begin
                ctrl.wr_addr = rd_addr;
                case (funct)
                    fn_add: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_add;
                    end
                    fn_sub: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_sub;
                    end
                    fn_and: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_and;
                    end
                    fn_or: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_or;
                    end
                    fn_slt: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_slt;
                    end
                    fn_jr:   ctrl.jump_reg = 1'b1;
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            op_addi: begin
                ctrl.reg_write = 1'b1;
                ctrl.wr_addr   = rt_addr;
                ctrl.alu_src   = 1'b1;
            end
            op_lw: begin
                ctrl.reg_write = 1'b1;
                ctrl.wr_addr   = rt_addr;
                ctrl.alu_src   = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = wb_mem;
            end
            op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            // compare by subtraction, zero flag decides
            op_beq: begin
                ctrl.alu_op = alu_sub;
                ctrl.branch = 1'b1;
            end
            op_j: begin
                ctrl.jump = 1'b1;
                ctrl.imm  = {6'b0, ir[25:0]};
            end
            op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.wr_addr   = 5'd31;
                ctrl.wb_sel    = wb_link;
                ctrl.jump      = 1'b1;
                ctrl.imm       = {6'b0, ir[25:0]};
            end
            default: ctrl.reg_write = 1'b0;
        endcase
    end

endmodule

//--- hw/mips_regfile.sv
// 32 x 32 register file, two combinational reads, one write per clock
// register 0 is never written, so it reads as zero after reset
// reset is synchronous and active high

`timescale 1ns/1ns

module mips_regfile
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  ctrl_t       ctrl,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [32];

    // write lands at the end of the cycle
    always_ff @(posedge clk) begin
        if (rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && (ctrl.wr_addr != 5'd0)) begin
            regs[ctrl.wr_addr] <= wr_data;
        end
    end

    // no bypass; same-cycle reads see the old value
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

//--- hw/mips_execute.sv
// ALU and next-pc selection, purely combinational
// slt is a signed compare; no overflow detection on add/sub
// next-pc priority: jr, then j/jal, then taken beq, then pc+4

`timescale 1ns/1ns

module mips_execute
    import mips_pkg::*;
(
    input  logic [31:0] pc,
    input  ctrl_t       ctrl,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic [31:0] alu_result,
    output logic [31:0] next_pc,
    output logic [31:0] link_pc
);

    logic [31:0] alu_b;
    logic        zero;
    logic [31:0] pc_plus4;
    logic [31:0] branch_target;
    logic [31:0] jump_target;

    // ==================================================
    // ALU
    // ==================================================

    assign alu_b = ctrl.alu_src ? ctrl.imm : rt_data;

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_result = rs_data + alu_b;
            alu_sub: alu_result = rs_data - alu_b;
            alu_and: alu_result = rs_data & alu_b;
            alu_or:  alu_result = rs_data | alu_b;
            alu_slt: alu_result = {31'b0, $signed(rs_data) < $signed(alu_b)};
            default: alu_result = '0;
        endcase
    end

    assign zero = (alu_result == 32'd0);

    // ==================================================
    // next pc
    // ==================================================

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {ctrl.imm[29:0], 2'b00};
    // upper nibble from pc+4, index from the instruction
    assign jump_target   = {pc_plus4[31:28], ctrl.imm[25:0], 2'b00};

    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = rs_data;
        end else if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (ctrl.branch && zero) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // return address for jal
    assign link_pc = pc_plus4;

endmodule

//--- hw/mips_result.sv
// data memory strobes and write-back selection
// strobes are active low with no handshake; memory read is combinational
// word addressing only, byte offset bits 1:0 are dropped

`timescale 1ns/1ns

module mips_result
    import mips_pkg::*;
#(
    parameter int dmem_aw = 7
) (
    input  ctrl_t               ctrl,
    input  logic [31:0]         alu_result,
    input  logic [31:0]         link_pc,
    input  logic [31:0]         rt_data,
    input  logic [31:0]         dmem_rdata,
    output logic                cen,
    output logic                wen,
    output logic                oen,
    output logic [dmem_aw-1:0]  dmem_addr,
    output logic [31:0]         dmem_wdata,
    output logic [31:0]         wr_data
);

    assign cen        = ~(ctrl.mem_read | ctrl.mem_write);
    assign wen        = ~ctrl.mem_write;
    assign oen        = ~ctrl.mem_read;
    assign dmem_addr  = alu_result[dmem_aw+1:2];
    assign dmem_wdata = rt_data;

    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wr_data = dmem_rdata;
            wb_link: wr_data = link_pc;
            default: wr_data = alu_result;
        endcase
    end

endmodule

//--- hw/mips_core.sv
// single-cycle MIPS-I subset core, one instruction per clock
// instruction and data memories must answer in the same cycle
// reset is synchronous and active high despite its name; pc starts at 0
// while in reset a no-operation is decoded, so no strobe or write fires

`timescale 1ns/1ns

module mips_core
    import mips_pkg::*;
#(
    parameter int dmem_aw = 7
) (
    input  logic               clk,
    input  logic               rst_n,
    // instruction fetch
    output logic [31:0]        ir_addr,
    input  logic [31:0]        ir,
    // data memory, active-low strobes
    output logic               cen,
    output logic               wen,
    output logic               oen,
    output logic [dmem_aw-1:0] dmem_addr,
    output logic [31:0]        dmem_wdata,
    input  logic [31:0]        dmem_rdata,
    // register write observation
    output logic               rf_wr_en,
    output logic [4:0]         rf_wr_addr,
    output logic [31:0]        rf_writedata
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] ir_dec;
    ctrl_t       ctrl;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_result;
    logic [31:0] link_pc;
    logic [31:0] wr_data;

    // ==================================================
    // program counter
    // ==================================================

    always_ff @(posedge clk) begin
        if (rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign ir_addr = pc;

    // all-zero word is sll, which decodes as a no-operation here
    assign ir_dec = rst_n ? 32'd0 : ir;

    // ==================================================
    // datapath
    // ==================================================

    mips_decode i_decode (
        .ir      (ir_dec),
        .ctrl    (ctrl),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr)
    );

    mips_regfile i_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .ctrl    (ctrl),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    mips_execute i_execute (
        .pc         (pc),
        .ctrl       (ctrl),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .alu_result (alu_result),
        .next_pc    (next_pc),
        .link_pc    (link_pc)
    );

    mips_result #(
        .dmem_aw (dmem_aw)
    ) i_result (
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .link_pc    (link_pc),
        .rt_data    (rt_data),
        .dmem_rdata (dmem_rdata),
        .cen        (cen),
        .wen        (wen),
        .oen        (oen),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .wr_data    (wr_data)
    );

    // observation; writes to r0 still show here but are dropped by the regfile
    assign rf_wr_en     = ctrl.reg_write;
    assign rf_wr_addr   = ctrl.wr_addr;
    assign rf_writedata = wr_data;

endmodule

//--- include/tb_program.svh
// directed program and instruction encoders for the core testbench
// included inside the testbench module; imem, prog_len and halt_pc must exist first
// immediates come from $urandom, so the seed is set before loading

`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// MIPS-I encodings for the program and the reference model
localparam logic [5:0] opc_rtype = 6'h00;
localparam logic [5:0] opc_j     = 6'h02;
localparam logic [5:0] opc_jal   = 6'h03;
localparam logic [5:0] opc_beq   = 6'h04;
localparam logic [5:0] opc_addi  = 6'h08;
localparam logic [5:0] opc_lw    = 6'h23;
localparam logic [5:0] opc_sw    = 6'h2b;
localparam logic [5:0] fnc_jr    = 6'h08;
localparam logic [5:0] fnc_add   = 6'h20;
localparam logic [5:0] fnc_sub   = 6'h22;
localparam logic [5:0] fnc_and   = 6'h24;
localparam logic [5:0] fnc_or    = 6'h25;
localparam logic [5:0] fnc_slt   = 6'h2a;

function automatic logic [31:0] enc_r(input int rs, input int rt, input int rd,
                                      input logic [5:0] fn);
    return {opc_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                      input logic [15:0] imm);
    return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic logic [31:0] enc_j(input logic [5:0] op, input int target);
    return {op, 26'(target)};
endfunction

task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
endtask

task automatic load_program();
    logic [15:0] imm_a;
    logic [15:0] imm_b;
    logic [15:0] imm_neg;
    logic [15:0] imm_r0;
    logic [15:0] base;
    imm_a   = 16'($urandom);
    imm_b   = 16'($urandom);
    imm_neg = 16'($urandom) | 16'h8000;
    imm_r0  = 16'($urandom) | 16'h0001;
    // nonzero word-aligned base inside the data memory
    base    = 16'((($urandom % 127) + 1) * 4);
    // unused words are harmless writes to r0 with a unique immediate each
    for (int i = 0; i < 64; i++) begin
        imem[i] = enc_i(opc_addi, 0, 0, 16'(i));
    end
    prog_len = 0;
    // arithmetic with a negative operand
    emit(enc_i(opc_addi, 0, 1, imm_a));
    emit(enc_i(opc_addi, 0, 2, imm_b));
    emit(enc_i(opc_addi, 0, 3, imm_neg));
    emit(enc_r(1, 2, 4, fnc_add));
    emit(enc_r(1, 2, 5, fnc_sub));
    emit(enc_r(1, 3, 6, fnc_and));
    emit(enc_r(2, 3, 7, fnc_or));
    emit(enc_r(3, 1, 8, fnc_slt));
    emit(enc_r(1, 3, 9, fnc_slt));
    // stores then loads of the same words
    emit(enc_i(opc_addi, 0, 10, base));
    emit(enc_i(opc_sw, 10, 4, 16'd0));
    emit(enc_i(opc_sw, 10, 5, 16'd4));
    emit(enc_i(opc_lw, 10, 11, 16'd0));
    emit(enc_i(opc_lw, 10, 12, 16'd4));
    // beq taken (14 -> 16), then not taken
    emit(enc_i(opc_beq, 11, 4, 16'd1));
    emit(enc_i(opc_addi, 0, 13, 16'd1));
    emit(enc_i(opc_beq, 10, 0, 16'd1));
    emit(enc_i(opc_addi, 0, 13, 16'd2));
    // j over one word, jal to a subroutine at 23
    emit(enc_j(opc_j, 20));
    emit(enc_i(opc_addi, 0, 14, 16'd3));
    emit(enc_j(opc_jal, 23));
    emit(enc_i(opc_addi, 0, 15, 16'd4));
    emit(enc_j(opc_j, 26));
    // subroutine writes r0, reads it back and returns by jr
    emit(enc_i(opc_addi, 0, 0, imm_r0));
    emit(enc_r(0, 1, 16, fnc_add));
    emit(enc_r(31, 0, 0, fnc_jr));
    emit(enc_i(opc_addi, 31, 17, 16'd8));
    // jr through a computed address (28 -> 30)
    emit(enc_i(opc_addi, 0, 18, 16'd120));
    emit(enc_r(18, 0, 0, fnc_jr));
    emit(enc_i(opc_addi, 0, 19, 16'd5));
    emit(enc_r(2, 2, 20, fnc_slt));
    emit(enc_r(0, 1, 21, fnc_sub));
    emit(enc_i(opc_sw, 10, 21, 16'd8));
    emit(enc_i(opc_lw, 10, 22, 16'd8));
    emit(enc_r(22, 0, 23, fnc_or));
    emit(enc_i(opc_beq, 0, 0, 16'd1));
    emit(enc_i(opc_addi, 0, 24, 16'd6));
    emit(enc_r(21, 1, 25, fnc_and));
    // final self-jump
    halt_pc = 32'(prog_len * 4);
    emit(enc_j(opc_j, prog_len));
endtask

`endif

//--- testbench/tb_mips_core.sv
// self-checking testbench for the single-cycle core
// a reference model steps once per cycle from the fetched word
// outputs are sampled on the falling edge, memories answer combinationally
// the run ends at the final self-jump or at a cycle limit

`timescale 1ns/1ns

module tb_mips_core;

    localparam int dmem_aw      = 7;
    localparam int reset_cycles = 3;

    logic               clk;
    logic               rst_n;
    logic [31:0]        ir_addr;
    logic [31:0]        ir;
    logic               cen;
    logic               wen;
    logic               oen;
    logic [dmem_aw-1:0] dmem_addr;
    logic [31:0]        dmem_wdata;
    logic [31:0]        dmem_rdata;
    logic               rf_wr_en;
    logic [4:0]         rf_wr_addr;
    logic [31:0]        rf_writedata;

    logic [31:0] imem [64];
    logic [31:0] dmem [2**dmem_aw];
    int          prog_len = 0;
    logic [31:0] halt_pc;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    int          halt_visits = 0;

    // reference model state
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_dmem [2**dmem_aw];

    `include "tb_program.svh"

    mips_core #(
        .dmem_aw (dmem_aw)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ir_addr      (ir_addr),
        .ir           (ir),
        .cen          (cen),
        .wen          (wen),
        .oen          (oen),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_rdata   (dmem_rdata),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_addr   (rf_wr_addr),
        .rf_writedata (rf_writedata)
    );

    // ==================================================
    // clock, reset and memory models
    // ==================================================

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n <= 1'b1;
        void'($urandom(2704));
        for (int i = 0; i < 2**dmem_aw; i++) begin
            dmem[i]   <= (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
            m_dmem[i] = (32'(i) * 32'h9e3779b1) ^ 32'h5a5a0000;
        end
        load_program();
        cycle_limit = 4 * prog_len + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b0;
    end

    assign ir         = imem[ir_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr];

    always @(posedge clk) begin
        if (!cen && !wen) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    // ==================================================
    // checking
    // ==================================================

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        $display("Verification failed");
        $fatal(1, "check failed");
    endtask

    task automatic check_reset();
        assert (ir_addr == 32'd0) else report_mismatch("ir_addr", ir_addr, 32'd0);
        assert (cen == 1'b1) else report_mismatch("cen", 32'(cen), 32'd1);
        assert (wen == 1'b1) else report_mismatch("wen", 32'(wen), 32'd1);
        assert (oen == 1'b1) else report_mismatch("oen", 32'(oen), 32'd1);
        assert (rf_wr_en == 1'b0) else report_mismatch("rf_wr_en", 32'(rf_wr_en), 32'd0);
        m_pc = 32'd0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = 32'd0;
        end
    endtask

    // compare one instruction against the ISA rules, then commit it
    task automatic check_and_step();
        logic [31:0] inst;
        logic [31:0] simm;
        logic [31:0] pc4;
        logic [31:0] next_pc;
        logic [31:0] maddr;
        logic [31:0] wd;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [4:0]  wa;
        logic        we;
        logic        exp_cen;
        logic        exp_wen;
        logic        exp_oen;
        inst    = imem[m_pc[7:2]];
        op_a    = m_regs[inst[25:21]];
        op_b    = m_regs[inst[20:16]];
        simm    = {{16{inst[15]}}, inst[15:0]};
        pc4     = m_pc + 32'd4;
        next_pc = pc4;
        we      = 1'b0;
        wa      = 5'd0;
        wd      = 32'd0;
        maddr   = 32'd0;
        exp_cen = 1'b1;
        exp_wen = 1'b1;
        exp_oen = 1'b1;
        case (inst[31:26])
            opc_rtype: begin
                we = 1'b1;
                wa = inst[15:11];
                case (inst[5:0])
                    fnc_add: wd = op_a + op_b;
                    fnc_sub: wd = op_a - op_b;
                    fnc_and: wd = op_a & op_b;
                    fnc_or:  wd = op_a | op_b;
                    fnc_slt: wd = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
                    fnc_jr: begin
                        we      = 1'b0;
                        next_pc = op_a;
                    end
                    default: we = 1'b0;
                endcase
            end
            opc_addi: begin
                we = 1'b1;
                wa = inst[20:16];
                wd = op_a + simm;
            end
            opc_lw: begin
                maddr   = op_a + simm;
                exp_cen = 1'b0;
                exp_oen = 1'b0;
                we      = 1'b1;
                wa      = inst[20:16];
                wd      = m_dmem[maddr[dmem_aw+1:2]];
            end
            opc_sw: begin
                maddr   = op_a + simm;
                exp_cen = 1'b0;
                exp_wen = 1'b0;
            end
            opc_beq: begin
                if (op_a == op_b) begin
                    next_pc = pc4 + {simm[29:0], 2'b00};
                end
            end
            opc_j: next_pc = {pc4[31:28], inst[25:0], 2'b00};
            opc_jal: begin
                next_pc = {pc4[31:28], inst[25:0], 2'b00};
                we      = 1'b1;
                wa      = 5'd31;
                wd      = pc4;
            end
            default: we = 1'b0;
        endcase

        assert (ir_addr == m_pc) else report_mismatch("ir_addr", ir_addr, m_pc);
        assert (cen == exp_cen) else report_mismatch("cen", 32'(cen), 32'(exp_cen));
        assert (wen == exp_wen) else report_mismatch("wen", 32'(wen), 32'(exp_wen));
        assert (oen == exp_oen) else report_mismatch("oen", 32'(oen), 32'(exp_oen));
        assert (rf_wr_en == we) else report_mismatch("rf_wr_en", 32'(rf_wr_en), 32'(we));
        if (we) begin
            assert (rf_wr_addr == wa)
                else report_mismatch("rf_wr_addr", 32'(rf_wr_addr), 32'(wa));
            assert (rf_writedata == wd)
                else report_mismatch("rf_writedata", rf_writedata, wd);
        end
        if (!exp_cen) begin
            assert (dmem_addr == maddr[dmem_aw+1:2])
                else report_mismatch("dmem_addr", 32'(dmem_addr), 32'(maddr[dmem_aw+1:2]));
        end
        if (!exp_wen) begin
            assert (dmem_wdata == op_b) else report_mismatch("dmem_wdata", dmem_wdata, op_b);
        end

        // commit; r0 stays zero
        if (m_pc == halt_pc) begin
            halt_visits++;
        end
        if (we && (wa != 5'd0)) begin
            m_regs[wa] = wd;
        end
        if (!exp_wen) begin
            m_dmem[maddr[dmem_aw+1:2]] = op_b;
        end
        m_pc = next_pc;
    endtask

    // second visit of the self-jump proves it loops
    always @(negedge clk) begin
        cycle_count++;
        if (rst_n) begin
            check_reset();
        end else begin
            check_and_step();
        end
        if (halt_visits >= 2) begin
            $display("Verification passed");
            $finish;
        end else if (cycle_count >= cycle_limit) begin
            $display("timeout: final self-jump not reached within %0d cycles", cycle_limit);
            $display("Verification failed");
            $fatal(1, "timeout");
        end
    end

endmodule

//--- vlog.f
+incdir+include
hw/mips_pkg.sv
hw/mips_decode.sv
hw/mips_regfile.sv
hw/mips_execute.sv
hw/mips_result.sv
hw/mips_core.sv
testbench/tb_mips_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f vlog.f \
    --top-module tb_mips_core \
    -o tb_mips_core_sim

./obj_dir/tb_mips_core_sim 2>&1 | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi
